// File: Makefile
OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module raster_tb \
		-f raster_top.f -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vraster_tb

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/alpha_blender.sv
`timescale 1ns/10ps
`default_nettype none
`include "raster_config.svh"

module alpha_blender (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [3:0] alpha,
	input raster_pkg::raster_color_t rd_data,   // One cycle after rd_en
	input logic grant,
	output logic rd_en,
	output logic wr_en,
	output raster_pkg::raster_addr_t addr,
	output raster_pkg::raster_color_t wr_data,
	output logic busy,
	output logic done
);

	import raster_pkg::*;

	localparam int CB = `RASTER_CANVAS_BITS;

	typedef enum logic [1:0] {PH_RD0, PH_RD1, PH_WR} phase_t;

	phase_t phase;
	logic [2*CB-1:0] pix_cnt;         // {y, x} of current pixel
	logic [3:0] alpha_q;
	logic rd0_q;                      // Layer 0 word arrives this cycle
	raster_color_t l0_q;              // Layer 0 colour between the two reads

	// (a*top + (16-a)*base) / 16, truncated
	function automatic logic [7:0] mix(input logic [7:0] top, input logic [7:0] base,
		input logic [3:0] a);
		logic [12:0] sum;
		sum = 13'(a) * 13'(top) + (13'd16 - 13'(a)) * 13'(base);
		return sum[11:4];
	endfunction

	assign rd_en = busy && grant && (phase != PH_WR);
	assign wr_en = busy && grant && (phase == PH_WR);
	assign addr = make_addr(phase == PH_RD1, pix_cnt[2*CB-1:CB], pix_cnt[CB-1:0]);
	assign wr_data = '{r: mix(rd_data.r, l0_q.r, alpha_q), g: mix(rd_data.g, l0_q.g, alpha_q),
		b: mix(rd_data.b, l0_q.b, alpha_q)};    // rd_data holds layer 1 in the write phase

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			phase <= PH_RD0;
			pix_cnt <= '0;
			done <= 1'b0;
			rd0_q <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			rd0_q <= rd_en && (phase == PH_RD0);
			if (start)
			begin
				busy <= 1'b1;
				phase <= PH_RD0;
				pix_cnt <= '0;
			end
			else if (busy)
				case (phase)
					PH_RD0:
						if (grant)
							phase <= PH_RD1;
					PH_RD1:
						if (grant)
							phase <= PH_WR;
					default:
						if (!grant)
							phase <= PH_RD1;           // Layer 1 word is stale, read it again
						else
						begin
							phase <= PH_RD0;
							pix_cnt <= pix_cnt + 1'b1;
							if (pix_cnt == '1)
							begin
								busy <= 1'b0;
								done <= 1'b1;
							end
						end
				endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
			alpha_q <= alpha;
		if (rd0_q)
			l0_q <= rd_data;
	end

endmodule

`default_nettype wire

// File: hdl/credit_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic push,                 // Sender only pushes while holding a credit
	input payload_t push_data,
	input logic pop,
	output payload_t head,            // Show-ahead, valid while not_empty
	output logic not_empty,
	output logic credit               // Registered pulse per popped entry
);

	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_BITS = $clog2(DEPTH + 1);

	payload_t slots [DEPTH];          // Storage ring
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS-1:0] wr_ptr;
	logic [CNT_BITS-1:0] count;       // Occupied slots
	logic do_pop;

	// Wraps at DEPTH so non power of two depths also work
	function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
		return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign not_empty = (count != '0);
	assign do_pop = pop && not_empty;      // Pop on empty is ignored
	assign head = slots[rd_ptr];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end
		else
		begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_pop)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_BITS'(push) - CNT_BITS'(do_pop);
			credit <= do_pop;                  // Slot handed back one cycle later
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			slots[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

// File: hdl/inst_dispatch.sv
`timescale 1ns/10ps
`default_nettype none

module inst_dispatch (
	input logic clk,
	input logic rst_n,
	input raster_pkg::raster_inst_t inst,     // Head of the instruction queue
	input logic inst_ready,
	input logic line_idle,
	input logic pix_drained,
	input logic blend_end,
	output logic inst_pop,
	output logic line_start,
	output logic [7:0] line_x0,
	output logic [7:0] line_y0,
	output logic [7:0] line_x1,
	output logic [7:0] line_y1,
	output raster_pkg::raster_color_t line_color,
	output logic line_layer,
	output logic blend_start,
	output logic [3:0] blend_alpha,
	output logic draw_done,
	output logic alpha_done
);

	import raster_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_EDGE,          // Launch current edge
		ST_EDGE_WAIT,     // Line engine walking
		ST_DRAIN,         // Last pixels still queued or in flight
		ST_BLEND_WAIT,
		ST_BLEND_GO,
		ST_BLEND_RUN
	} state_t;

	state_t state;
	raster_inst_t inst_q;           // Instruction being executed
	logic [1:0] edge_idx;           // 0 v0-v1, 1 v1-v2, 2 v2-v0

	assign inst_pop = (state == ST_IDLE) && inst_ready;
	assign line_start = (state == ST_EDGE);
	assign blend_start = (state == ST_BLEND_GO);
	assign line_color = inst_q.color;
	assign line_layer = inst_q.layer_num;
	assign blend_alpha = inst_q.alpha_val;

	always_comb
	begin
		line_x0 = inst_q.x0;
		line_y0 = inst_q.y0;
		line_x1 = inst_q.x1;
		line_y1 = inst_q.y1;
		case (edge_idx)
			2'd1:
			begin
				line_x0 = inst_q.x1;
				line_y0 = inst_q.y1;
				line_x1 = inst_q.x2;
				line_y1 = inst_q.y2;
			end
			2'd2:
			begin
				line_x0 = inst_q.x2;
				line_y0 = inst_q.y2;
				line_x1 = inst_q.x0;
				line_y1 = inst_q.y0;
			end
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= ST_IDLE;
			edge_idx <= 2'd0;
			draw_done <= 1'b0;
			alpha_done <= 1'b0;
		end
		else
		begin
			draw_done <= 1'b0;
			alpha_done <= 1'b0;
			case (state)
				ST_IDLE:
					if (inst_ready)
					begin
						edge_idx <= 2'd0;
						state <= inst_is_blend(inst) ? ST_BLEND_WAIT : ST_EDGE;
					end
				ST_EDGE:
					state <= ST_EDGE_WAIT;     // Engine is busy from the next cycle
				ST_EDGE_WAIT:
					if (line_idle)
					begin
						if (edge_idx == inst_last_edge(inst_q))
							state <= ST_DRAIN;
						else
						begin
							edge_idx <= edge_idx + 2'd1;
							state <= ST_EDGE;
						end
					end
				ST_DRAIN:
					if (line_idle && pix_drained)
					begin
						draw_done <= 1'b1;
						state <= ST_IDLE;
					end
				ST_BLEND_WAIT:
					if (pix_drained)
						state <= ST_BLEND_GO;
				ST_BLEND_GO:
					state <= ST_BLEND_RUN;
				default:
					if (blend_end)
					begin
						alpha_done <= 1'b1;
						state <= ST_IDLE;
					end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (inst_pop)
			inst_q <= inst;
	end

endmodule

`default_nettype wire

// File: hdl/line_engine.sv
`timescale 1ns/10ps
`default_nettype none
`include "raster_config.svh"

module line_engine (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic [7:0] x0,
	input logic [7:0] y0,
	input logic [7:0] x1,
	input logic [7:0] y1,
	input raster_pkg::raster_color_t color,
	input logic layer,
	output logic idle,
	pixel_if.src pix
);

	import raster_pkg::*;

	localparam int CRED_BITS = $clog2(`RASTER_PIX_DEPTH + 1);

	logic busy;
	logic [7:0] cur_x;
	logic [7:0] cur_y;
	logic [7:0] end_x;
	logic [7:0] end_y;
	logic x_neg;                        // Step direction of x
	logic y_neg;
	logic signed [9:0] dx;              // |x1-x0|
	logic signed [9:0] dy;              // -|y1-y0|
	logic signed [11:0] err;            // Bresenham error term
	logic signed [11:0] e2;
	raster_color_t color_q;
	logic layer_q;
	logic [CRED_BITS-1:0] credits;      // Free slots in the pixel queue
	logic [7:0] abs_dx;
	logic [7:0] abs_dy;
	logic signed [9:0] start_err;
	logic in_canvas;
	logic issue;
	logic advance;
	logic at_end;
	logic step_x;
	logic step_y;

	assign abs_dx = (x1 >= x0) ? x1 - x0 : x0 - x1;
	assign abs_dy = (y1 >= y0) ? y1 - y0 : y0 - y1;
	assign start_err = $signed({2'b00, abs_dx}) - $signed({2'b00, abs_dy});

	assign in_canvas = (cur_x[7:`RASTER_CANVAS_BITS] == '0) && (cur_y[7:`RASTER_CANVAS_BITS] == '0);
	assign issue = busy && in_canvas && (credits != '0);
	assign advance = busy && (!in_canvas || (credits != '0));   // Clipped points cost no credit
	assign at_end = (cur_x == end_x) && (cur_y == end_y);
	assign e2 = err <<< 1;
	assign step_x = (e2 >= 12'(dy));
	assign step_y = (e2 <= 12'(dx));

	assign idle = !busy;
	assign pix.valid = issue;
	assign pix.pixel = '{x: cur_x[`RASTER_CANVAS_BITS-1:0], y: cur_y[`RASTER_CANVAS_BITS-1:0],
		layer: layer_q, color: color_q};

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			busy <= 1'b0;
			credits <= CRED_BITS'(`RASTER_PIX_DEPTH);
		end
		else
		begin
			if (start)
				busy <= 1'b1;
			else if (advance && at_end)
				busy <= 1'b0;                  // End point included
			credits <= credits - CRED_BITS'(issue) + CRED_BITS'(pix.credit);
		end
	end

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			cur_x <= x0;
			cur_y <= y0;
			end_x <= x1;
			end_y <= y1;
			x_neg <= (x1 < x0);
			y_neg <= (y1 < y0);
			dx <= $signed({2'b00, abs_dx});
			dy <= -$signed({2'b00, abs_dy});
			err <= 12'(start_err);
			color_q <= color;
			layer_q <= layer;
		end
		else if (advance && !at_end)         // Holds position while out of credits
		begin
			if (step_x)
				cur_x <= x_neg ? cur_x - 8'd1 : cur_x + 8'd1;
			if (step_y)
				cur_y <= y_neg ? cur_y - 8'd1 : cur_y + 8'd1;
			err <= err + (step_x ? 12'(dy) : 12'sd0) + (step_y ? 12'(dx) : 12'sd0);
		end
	end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
	input logic clk,
	input logic rst_n,
	input raster_pkg::raster_pixel_t pix_head,   // Head of the pixel queue
	input logic pix_ready,
	input logic blend_busy,
	input logic blend_rd_en,
	input logic blend_wr_en,
	input raster_pkg::raster_addr_t blend_addr,
	input raster_pkg::raster_color_t blend_wr_data,
	output logic pix_pop,
	output logic pix_drained,
	output logic mem_read_enable,
	output logic mem_write_enable,
	output raster_pkg::raster_addr_t mem_address,
	output raster_pkg::raster_color_t mem_write_data
);

	import raster_pkg::*;

	logic pix_wr_q;                   // Pixel write on the port this cycle
	raster_addr_t pix_addr_q;
	raster_color_t pix_data_q;

	assign pix_pop = pix_ready && !blend_busy;     // Blender has priority
	assign pix_drained = !pix_ready && !pix_wr_q;

	// Blender drives the port straight through, pixel writes come from registers
	assign mem_read_enable = blend_busy && blend_rd_en;
	assign mem_write_enable = blend_busy ? blend_wr_en : pix_wr_q;
	assign mem_address = blend_busy ? blend_addr : pix_addr_q;
	assign mem_write_data = blend_busy ? blend_wr_data : pix_data_q;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pix_wr_q <= 1'b0;
		else
			pix_wr_q <= pix_pop;            // Write lands the cycle after the pop
	end

	always_ff @(posedge clk)
	begin
		if (pix_pop)
		begin
			pix_addr_q <= make_addr(pix_head.layer, pix_head.y, pix_head.x);
			pix_data_q <= pix_head.color;
		end
	end

endmodule

`default_nettype wire

// File: hdl/pixel_if.sv
`timescale 1ns/10ps
`default_nettype none

interface pixel_if;

	logic valid;                        // One pixel offered this cycle
	raster_pkg::raster_pixel_t pixel;   // Coordinates, layer and colour
	logic credit;                       // Pulse per slot freed in the queue

	modport src
	(
		output valid,
		output pixel,
		input credit
	);

	modport dst
	(
		input valid,
		input pixel,
		output credit
	);

endinterface

`default_nettype wire

// File: hdl/raster_config.svh
`ifndef RASTER_CONFIG_SVH
`define RASTER_CONFIG_SVH

// Canvas is 2**CANVAS_BITS pixels on a side
`define RASTER_CANVAS_BITS 5

`define RASTER_INST_DEPTH 4     // Instruction queue slots, also sender credits
`define RASTER_PIX_DEPTH 4      // Pixel queue slots, also line engine credits

`define RASTER_ADDR_BITS 11     // Layer, y, x
`define RASTER_DATA_BITS 24     // One RGB word

`endif

// File: hdl/raster_pkg.sv
`default_nettype none
`include "raster_config.svh"

package raster_pkg;

	typedef logic [`RASTER_CANVAS_BITS-1:0] raster_coord_t;    // In-canvas coordinate

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} raster_color_t;

	// Declared MSB first, so inst_type lands on bit 0
	typedef struct packed {
		logic [3:0] alpha_val;       // Blend weight of layer 1, top bits
		logic [1:0] texture_code;    // Not used by the engines
		raster_color_t color;
		logic fill_type;             // Not used by the engines
		logic layer_num;             // Target layer of a draw
		logic [7:0] y2;
		logic [7:0] x2;
		logic [7:0] y1;
		logic [7:0] x1;
		logic [7:0] y0;
		logic [7:0] x0;
		logic vertice_num;           // 1 triangle, 0 single line
		logic inst_type;             // 0 draw, 1 blend
	} raster_inst_t;

	typedef struct packed {
		raster_coord_t x;
		raster_coord_t y;
		logic layer;
		raster_color_t color;
	} raster_pixel_t;

	typedef struct packed {
		logic layer;                 // Layer selects the upper half of the SRAM
		raster_coord_t y;
		raster_coord_t x;
	} raster_addr_t;

	function automatic logic inst_is_blend(input raster_inst_t inst);
		return inst.inst_type;
	endfunction

	// Index of the final edge, 0 for a line and 2 for a triangle
	function automatic logic [1:0] inst_last_edge(input raster_inst_t inst);
		return inst.vertice_num ? 2'd2 : 2'd0;
	endfunction

	function automatic raster_addr_t make_addr(
		input logic layer,
		input raster_coord_t y,
		input raster_coord_t x
	);
		return '{layer: layer, y: y, x: x};
	endfunction

endpackage

`default_nettype wire

// File: hdl/raster_top.sv
`timescale 1ns/10ps
`default_nettype none
`include "raster_config.svh"

module raster_top (
	input logic clk,
	input logic rst_n,
	input logic inst_valid,
	input logic [$bits(raster_pkg::raster_inst_t)-1:0] inst_data,
	output logic inst_credit,
	output logic mem_read_enable,
	output logic mem_write_enable,
	output logic [`RASTER_ADDR_BITS-1:0] mem_address,
	input logic [`RASTER_DATA_BITS-1:0] mem_read_data,
	output logic [`RASTER_DATA_BITS-1:0] mem_write_data,
	output logic draw_done,
	output logic alpha_done
);

	import raster_pkg::*;

	raster_inst_t inst_head;
	logic inst_ready;
	logic inst_pop;
	logic line_start;
	logic line_idle;
	logic [7:0] line_x0;
	logic [7:0] line_y0;
	logic [7:0] line_x1;
	logic [7:0] line_y1;
	raster_color_t line_color;
	logic line_layer;
	logic blend_start;
	logic blend_end;
	logic [3:0] blend_alpha;
	raster_pixel_t pix_head;
	logic pix_ready;
	logic pix_pop;
	logic pix_drained;
	logic blend_busy;
	logic blend_rd_en;
	logic blend_wr_en;
	raster_addr_t blend_addr;
	raster_color_t blend_wr_data;

	pixel_if pix_bus ();

	credit_fifo #(.payload_t(raster_inst_t), .DEPTH(`RASTER_INST_DEPTH)) u_inst_fifo (
		.clk(clk), .rst_n(rst_n), .push(inst_valid), .push_data(inst_data),
		.pop(inst_pop), .head(inst_head), .not_empty(inst_ready), .credit(inst_credit)
	);

	inst_dispatch u_dispatch (
		.clk(clk), .rst_n(rst_n), .inst(inst_head), .inst_ready(inst_ready),
		.line_idle(line_idle), .pix_drained(pix_drained), .blend_end(blend_end),
		.inst_pop(inst_pop), .line_start(line_start), .line_x0(line_x0), .line_y0(line_y0),
		.line_x1(line_x1), .line_y1(line_y1), .line_color(line_color),
		.line_layer(line_layer), .blend_start(blend_start), .blend_alpha(blend_alpha),
		.draw_done(draw_done), .alpha_done(alpha_done)
	);

	line_engine u_line (
		.clk(clk), .rst_n(rst_n), .start(line_start), .x0(line_x0), .y0(line_y0),
		.x1(line_x1), .y1(line_y1), .color(line_color), .layer(line_layer),
		.idle(line_idle), .pix(pix_bus.src)
	);

	// Pixel queue is the sink side of pix_bus
	credit_fifo #(.payload_t(raster_pixel_t), .DEPTH(`RASTER_PIX_DEPTH)) u_pix_fifo (
		.clk(clk), .rst_n(rst_n), .push(pix_bus.valid), .push_data(pix_bus.pixel),
		.pop(pix_pop), .head(pix_head), .not_empty(pix_ready), .credit(pix_bus.credit)
	);

	alpha_blender u_blend (
		.clk(clk), .rst_n(rst_n), .start(blend_start), .alpha(blend_alpha),
		.rd_data(mem_read_data), .grant(pix_drained), .rd_en(blend_rd_en),
		.wr_en(blend_wr_en), .addr(blend_addr), .wr_data(blend_wr_data),
		.busy(blend_busy), .done(blend_end)
	);

	mem_arbiter u_arb (
		.clk(clk), .rst_n(rst_n), .pix_head(pix_head), .pix_ready(pix_ready),
		.blend_busy(blend_busy), .blend_rd_en(blend_rd_en), .blend_wr_en(blend_wr_en),
		.blend_addr(blend_addr), .blend_wr_data(blend_wr_data), .pix_pop(pix_pop),
		.pix_drained(pix_drained), .mem_read_enable(mem_read_enable),
		.mem_write_enable(mem_write_enable), .mem_address(mem_address),
		.mem_write_data(mem_write_data)
	);

endmodule

`default_nettype wire

// File: raster_top.f
+incdir+hdl
hdl/raster_pkg.sv
hdl/pixel_if.sv
hdl/credit_fifo.sv
hdl/inst_dispatch.sv
hdl/line_engine.sv
hdl/alpha_blender.sv
hdl/mem_arbiter.sv
hdl/raster_top.sv
sim/raster_sva.sv
sim/raster_tb.sv

// File: sim/raster_sva.sv
`timescale 1ns/10ps
`default_nettype none
`include "raster_config.svh"

module raster_sva (
	input logic clk,
	input logic rst_n,
	input logic inst_credit,
	input logic mem_read_enable,
	input logic mem_write_enable,
	input logic [`RASTER_ADDR_BITS-1:0] mem_address,
	input logic draw_done,
	input logic alpha_done
);

	int credit_run;                        // Back to back inst_credit cycles

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			credit_run <= 0;
		else
			credit_run <= inst_credit ? credit_run + 1 : 0;
	end

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !(inst_credit || mem_read_enable || mem_write_enable || draw_done || alpha_done))
		else $error("Control output active during reset");

	no_rw_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read_enable && mem_write_enable))
		else $error("SRAM read and write enabled together");

	// Every access names a defined word of the two layers
	addr_known: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read_enable || mem_write_enable) |-> !$isunknown(mem_address))
		else $error("SRAM address undefined during an access");

	done_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(draw_done && alpha_done))
		else $error("draw_done and alpha_done pulsed together");

	credit_burst: assert property (@(posedge clk) disable iff (!rst_n)
		credit_run <= `RASTER_INST_DEPTH)
		else $error("inst_credit returned more slots than the queue holds");

endmodule

bind raster_top raster_sva u_sva (
	.clk(clk), .rst_n(rst_n), .inst_credit(inst_credit),
	.mem_read_enable(mem_read_enable), .mem_write_enable(mem_write_enable),
	.mem_address(mem_address), .draw_done(draw_done), .alpha_done(alpha_done)
);

`default_nettype wire

// File: sim/raster_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "raster_config.svh"

module raster_tb;

	import raster_pkg::*;

	localparam int SIDE = 1 << `RASTER_CANVAS_BITS;
	localparam int LAYER_WORDS = SIDE * SIDE;
	localparam int MEM_WORDS = 1 << `RASTER_ADDR_BITS;
	localparam int LIMIT = 20000;              // Cycles allowed for any single wait

	logic clk;
	logic rst_n;
	logic inst_valid;
	logic [$bits(raster_inst_t)-1:0] inst_data;
	logic inst_credit;
	logic mem_read_enable;
	logic mem_write_enable;
	logic [`RASTER_ADDR_BITS-1:0] mem_address;
	logic [`RASTER_DATA_BITS-1:0] mem_read_data;
	logic [`RASTER_DATA_BITS-1:0] mem_write_data;
	logic draw_done;
	logic alpha_done;

	logic [23:0] sram [MEM_WORDS];             // SRAM model contents
	logic [23:0] exp_mem [MEM_WORDS];          // Expected image
	int wr_count;
	int rd_count;
	int draw_count;
	int alpha_count;
	int credit_back;                           // inst_credit pulses seen
	int sent;                                  // Instructions pushed
	int exp_writes;                            // In-canvas points predicted
	int held_cycles;                           // Cycles the last send waited for a credit
	logic [15:0] lfsr;

	raster_top u_dut (
		.clk(clk), .rst_n(rst_n), .inst_valid(inst_valid), .inst_data(inst_data),
		.inst_credit(inst_credit), .mem_read_enable(mem_read_enable),
		.mem_write_enable(mem_write_enable), .mem_address(mem_address),
		.mem_read_data(mem_read_data), .mem_write_data(mem_write_data),
		.draw_done(draw_done), .alpha_done(alpha_done)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;
	end

	// Single port, read data one cycle after the enable
	always @(posedge clk)
	begin
		if (mem_write_enable)
			sram[mem_address] <= mem_write_data;
		if (mem_read_enable)
			mem_read_data <= sram[mem_address];
	end

	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			wr_count <= 0;
			rd_count <= 0;
			draw_count <= 0;
			alpha_count <= 0;
			credit_back <= 0;
		end
		else
		begin
			if (mem_write_enable)
				wr_count <= wr_count + 1;
			if (mem_read_enable)
				rd_count <= rd_count + 1;
			if (draw_done)
				draw_count <= draw_count + 1;
			if (alpha_done)
				alpha_count <= alpha_count + 1;
			if (inst_credit)
				credit_back <= credit_back + 1;
		end
	end

	// x^16 + x^15 + x^13 + x^4 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[14] ^ s[12] ^ s[3]};
	endfunction

	task automatic rand_color(output logic [23:0] c);
		int i;
		for (i = 0; i < 24; i++)
		begin
			lfsr = lfsr_next(lfsr);            // One step per bit
			c = {c[22:0], lfsr[0]};
		end
	endtask

	task automatic report_fail(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input int exp, input int act);
		assert (act == exp)
		else
			report_fail($sformatf("FAILED %s: expected %0d, actual %0d", name, exp, act));
	endtask

	task automatic check_mem(input string name);
		int a;
		for (a = 0; a < MEM_WORDS; a++)
			assert (sram[a] == exp_mem[a])
			else
				report_fail($sformatf("FAILED %s at word %0d: expected %h, actual %h",
					name, a, exp_mem[a], sram[a]));
	endtask

	task automatic check_idle(input string name);
		check_val({name, " inst_credit"}, 0, int'(inst_credit));
		check_val({name, " draw_done"}, 0, int'(draw_done));
		check_val({name, " alpha_done"}, 0, int'(alpha_done));
		check_val({name, " mem_read_enable"}, 0, int'(mem_read_enable));
		check_val({name, " mem_write_enable"}, 0, int'(mem_write_enable));
	endtask

	// Reference Bresenham walk, end point included, clipped to the canvas
	task automatic plot_line(input int x0, input int y0, input int x1, input int y1,
		input int layer, input logic [23:0] color);
		int dx;
		int dy;
		int sx;
		int sy;
		int err;
		int e2;
		int x;
		int y;
		bit walking;
		dx = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy = (y1 > y0) ? y0 - y1 : y1 - y0;    // Negative magnitude
		sx = (x1 >= x0) ? 1 : -1;
		sy = (y1 >= y0) ? 1 : -1;
		err = dx + dy;
		x = x0;
		y = y0;
		walking = 1'b1;
		while (walking)
		begin
			if (x < SIDE && y < SIDE)
			begin
				exp_mem[layer * LAYER_WORDS + y * SIDE + x] = color;
				exp_writes++;
			end
			if (x == x1 && y == y1)
				walking = 1'b0;
			else
			begin
				e2 = 2 * err;
				if (e2 >= dy)
				begin
					err += dy;
					x += sx;
				end
				if (e2 <= dx)
				begin
					err += dx;
					y += sy;
				end
			end
		end
	endtask

	function automatic logic [7:0] mix_chan(input int a, input logic [7:0] l1,
		input logic [7:0] l0);
		return 8'((a * int'(l1) + (16 - a) * int'(l0)) / 16);
	endfunction

	task automatic blend_model(input int a);
		int p;
		logic [23:0] l0;
		logic [23:0] l1;
		for (p = 0; p < LAYER_WORDS; p++)
		begin
			l0 = exp_mem[p];
			l1 = exp_mem[p + LAYER_WORDS];
			exp_mem[p] = {mix_chan(a, l1[23:16], l0[23:16]), mix_chan(a, l1[15:8], l0[15:8]),
				mix_chan(a, l1[7:0], l0[7:0])};
		end
	endtask

	function automatic raster_inst_t draw_inst(input logic is_tri, input int x0, input int y0,
		input int x1, input int y1, input int x2, input int y2, input logic layer,
		input logic [23:0] color);
		raster_inst_t p;
		p = '0;
		p.vertice_num = is_tri;
		p.x0 = 8'(x0);
		p.y0 = 8'(y0);
		p.x1 = 8'(x1);
		p.y1 = 8'(y1);
		p.x2 = 8'(x2);
		p.y2 = 8'(y2);
		p.layer_num = layer;
		p.color = color;
		return p;
	endfunction

	function automatic raster_inst_t blend_inst(input int a);
		raster_inst_t p;
		p = '0;
		p.inst_type = 1'b1;
		p.alpha_val = 4'(a);
		return p;
	endfunction

	// Pushes only while a credit is held
	task automatic send_inst(input raster_inst_t pkt);
		held_cycles = 0;
		while (`RASTER_INST_DEPTH - sent + credit_back <= 0)
		begin
			@(posedge clk);
			inst_valid <= 1'b0;
			held_cycles++;
			if (held_cycles > LIMIT)
				report_fail("Timeout waiting for an instruction credit");
		end
		@(posedge clk);
		inst_valid <= 1'b1;
		inst_data <= pkt;
		sent++;
	endtask

	task automatic idle_input();
		@(posedge clk);
		inst_valid <= 1'b0;
	endtask

	task automatic wait_done(input int draws, input int blends, input string name);
		int cycles;
		cycles = 0;
		while (draw_count < draws || alpha_count < blends)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > LIMIT)
				report_fail($sformatf("Timeout waiting for the done pulses of %s", name));
		end
	endtask

	task automatic wait_credits();
		int cycles;
		cycles = 0;
		while (credit_back < sent)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > LIMIT)
				report_fail("Timeout waiting for inst_credit to return");
		end
	endtask

	initial
	begin
		int i;
		int base;
		logic [23:0] c;
		logic [23:0] c_last;
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst_data = '0;
		sent = 0;
		lfsr = 16'd41;
		mem_read_data <= '0;
		for (i = 0; i < MEM_WORDS; i++)
		begin
			sram[i] <= '0;                     // Model starts zeroed
			exp_mem[i] = '0;
		end

		repeat (4)
		begin
			@(negedge clk);
			check_idle("reset");
		end
		@(posedge clk);
		rst_n <= 1'b1;                         // Fifth rising edge ends reset
		repeat (4)
		begin
			@(negedge clk);
			check_idle("after reset");
		end
		check_val("reset writes", 0, wr_count);
		check_val("reset reads", 0, rd_count);

		// Horizontal and vertical lines in layer 0
		rand_color(c);
		base = wr_count;
		send_inst(draw_inst(1'b0, 3, 10, 12, 10, 0, 0, 1'b0, c));
		idle_input();
		plot_line(3, 10, 12, 10, 0, c);
		wait_done(1, 0, "line_h");
		check_val("line_h writes", 10, wr_count - base);
		check_mem("line_h");
		rand_color(c);
		base = wr_count;
		send_inst(draw_inst(1'b0, 20, 1, 20, 15, 0, 0, 1'b0, c));
		idle_input();
		plot_line(20, 1, 20, 15, 0, c);
		wait_done(2, 0, "line_v");
		check_val("line_v writes", 15, wr_count - base);
		check_mem("line_v");

		// Triangle edges in layer 1
		rand_color(c);
		base = wr_count;
		exp_writes = 0;
		send_inst(draw_inst(1'b1, 2, 2, 2, 20, 18, 2, 1'b1, c));
		idle_input();
		plot_line(2, 2, 2, 20, 1, c);
		plot_line(2, 20, 18, 2, 1, c);
		plot_line(18, 2, 2, 2, 1, c);
		wait_done(3, 0, "triangle");
		check_val("triangle writes", exp_writes, wr_count - base);
		check_mem("triangle");

		// Right half of the line falls off the canvas
		rand_color(c);
		base = wr_count;
		send_inst(draw_inst(1'b0, 25, 5, 40, 5, 0, 0, 1'b0, c));
		idle_input();
		plot_line(25, 5, 40, 5, 0, c);
		wait_done(4, 0, "clip");
		check_val("clip writes", 7, wr_count - base);
		check_mem("clip");

		send_inst(blend_inst(8));
		idle_input();
		blend_model(8);
		wait_done(4, 1, "blend");
		check_val("blend draw_done", 4, draw_count);
		check_mem("blend");

		// Long blend keeps the dispatcher busy while the queue fills
		// Each pair of neighbouring draws shares a pixel, so order shows in the image
		send_inst(blend_inst(4));
		idle_input();
		blend_model(4);
		wait_credits();
		rand_color(c);
		send_inst(draw_inst(1'b0, 0, 20, 20, 20, 0, 0, 1'b0, c));
		plot_line(0, 20, 20, 20, 0, c);
		rand_color(c);
		send_inst(draw_inst(1'b0, 12, 10, 12, 30, 0, 0, 1'b0, c));
		plot_line(12, 10, 12, 30, 0, c);
		rand_color(c);
		send_inst(draw_inst(1'b0, 5, 15, 15, 25, 0, 0, 1'b0, c));
		plot_line(5, 15, 15, 25, 0, c);
		rand_color(c);
		send_inst(draw_inst(1'b0, 15, 15, 5, 25, 0, 0, 1'b0, c));
		plot_line(15, 15, 5, 25, 0, c);
		check_val("credits left", 0, `RASTER_INST_DEPTH - sent + credit_back);
		rand_color(c_last);
		send_inst(draw_inst(1'b0, 8, 22, 8, 22, 0, 0, 1'b0, c_last));
		idle_input();
		plot_line(8, 22, 8, 22, 0, c_last);
		if (held_cycles == 0)
			report_fail("Fifth instruction was accepted without a returned credit");
		wait_done(9, 2, "credits");
		check_val("order last colour", int'(c_last), int'(sram[22 * SIDE + 8]));
		check_mem("credits");

		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
